// File: axis_reg_slice.sv
`timescale 1ns/100ps

module axis_reg_slice (
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic                    s_valid,
    output logic                    s_ready,
    input  mvm_noc_pkg::noc_flit_t  s_flit,

    output logic                    m_valid,
    input  logic                    m_ready,
    output mvm_noc_pkg::noc_flit_t  m_flit
);
    import mvm_noc_pkg::*;

    // Skid entry catches the beat taken while the output stalls
    logic      skid_valid;
    noc_flit_t skid_flit;
    logic      s_fire;
    logic      m_free;

    // Ready comes straight from a flop
    assign s_ready = !skid_valid;
    assign s_fire  = s_valid && s_ready;
    assign m_free  = !m_valid || m_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_valid    <= 1'b0;
            skid_valid <= 1'b0;
        end else if (m_free) begin
            // Drain skid first, else take the new beat
            m_valid    <= skid_valid || s_fire;
            skid_valid <= 1'b0;
        end else if (s_fire) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (m_free) begin
            m_flit <= skid_valid ? skid_flit : s_flit;
        end
        if (s_fire && !m_free) begin
            skid_flit <= s_flit;
        end
    end

endmodule

// File: mvm_noc.sv
`timescale 1ns/100ps
`include "mvm_noc_cfg.svh"

module mvm_noc (
    input  logic                    clk,
    input  logic                    arst_n,

    // Stream slave
    input  logic                    s_valid,
    output logic                    s_ready,
    input  mvm_noc_pkg::noc_flit_t  s_flit,

    // Stream master
    output logic                    m_valid,
    input  logic                    m_ready,
    output mvm_noc_pkg::noc_flit_t  m_flit
);
    import mvm_noc_pkg::*;

    localparam int NODES = `MVM_ROWS * `MVM_COLS;

    // Named from the mesh side, in enters the mesh
    logic      loc_in_valid  [NODES];
    logic      loc_in_ready  [NODES];
    noc_flit_t loc_in_flit   [NODES];
    logic      loc_out_valid [NODES];
    logic      loc_out_ready [NODES];
    noc_flit_t loc_out_flit  [NODES];

    // ---------------------------------------------------------
    // Ingress slice into node 0
    // ---------------------------------------------------------
    axis_reg_slice i_ingress (
        .clk     (clk),
        .arst_n  (arst_n),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .s_flit  (s_flit),
        .m_valid (loc_in_valid[`MVM_IN_NODE]),
        .m_ready (loc_in_ready[`MVM_IN_NODE]),
        .m_flit  (loc_in_flit[`MVM_IN_NODE])
    );

    // Nothing is addressed to the ingress node
    assign loc_out_ready[`MVM_IN_NODE] = 1'b1;

    noc_mesh i_mesh (
        .clk             (clk),
        .arst_n          (arst_n),
        .local_in_valid  (loc_in_valid),
        .local_in_ready  (loc_in_ready),
        .local_in_flit   (loc_in_flit),
        .local_out_valid (loc_out_valid),
        .local_out_ready (loc_out_ready),
        .local_out_flit  (loc_out_flit)
    );

    // Tiles sit on the nodes between ingress and egress
    for (genvar n = `MVM_IN_NODE + 1; n < `MVM_OUT_NODE; n++) begin : g_tile
        mvm_tile i_tile (
            .clk      (clk),
            .arst_n   (arst_n),
            .rx_valid (loc_out_valid[n]),
            .rx_ready (loc_out_ready[n]),
            .rx_flit  (loc_out_flit[n]),
            .tx_valid (loc_in_valid[n]),
            .tx_ready (loc_in_ready[n]),
            .tx_flit  (loc_in_flit[n])
        );
    end

    // ---------------------------------------------------------
    // Egress slice out of node 3
    // ---------------------------------------------------------
    // No source injects at the egress node
    assign loc_in_valid[`MVM_OUT_NODE] = 1'b0;
    assign loc_in_flit[`MVM_OUT_NODE]  = '0;

    axis_reg_slice i_egress (
        .clk     (clk),
        .arst_n  (arst_n),
        .s_valid (loc_out_valid[`MVM_OUT_NODE]),
        .s_ready (loc_out_ready[`MVM_OUT_NODE]),
        .s_flit  (loc_out_flit[`MVM_OUT_NODE]),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_flit  (m_flit)
    );

endmodule

// File: mvm_noc_cfg.svh
`ifndef MVM_NOC_CFG_SVH
`define MVM_NOC_CFG_SVH

// Flit payload
`define MVM_DATAW       32
`define MVM_LANES       4
`define MVM_LANEW       8

// Tile accumulator
`define MVM_ACCW        32

// Mesh size, node number is x + cols * y
`define MVM_ROWS        2
`define MVM_COLS        2
`define MVM_DESTW       2

// Port attachment points
`define MVM_IN_NODE     0
`define MVM_OUT_NODE    3

// Router input buffer entries
`define MVM_FLIT_DEPTH  2

`endif

// File: mvm_noc_pkg.sv
`include "mvm_noc_cfg.svh"

package mvm_noc_pkg;

    // ---------------------------------------------------------
    // Opcodes carried in the flit user field
    // ---------------------------------------------------------
    typedef enum logic [1:0] {
        OP_WEIGHT = 2'd0,
        OP_VECTOR = 2'd1,
        OP_RESULT = 2'd2,
        OP_PASS   = 2'd3
    } mvm_op_e;

    // One beat on any link, 37 bits
    typedef struct packed {
        logic [`MVM_DATAW-1:0] data;
        logic                  last;
        mvm_op_e               op;
        logic [`MVM_DESTW-1:0] dest;
    } noc_flit_t;

    // ---------------------------------------------------------
    // Router ports
    // ---------------------------------------------------------
    // North is +y, east is +x
    typedef enum logic [2:0] {
        PORT_LOCAL = 3'd0,
        PORT_EAST  = 3'd1,
        PORT_WEST  = 3'd2,
        PORT_NORTH = 3'd3,
        PORT_SOUTH = 3'd4
    } noc_port_e;

    localparam int NOC_PORTS = 5;

endpackage

// File: mvm_tile.sv
`timescale 1ns/100ps
`include "mvm_noc_cfg.svh"

module mvm_tile (
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic                    rx_valid,
    output logic                    rx_ready,
    input  mvm_noc_pkg::noc_flit_t  rx_flit,

    output logic                    tx_valid,
    input  logic                    tx_ready,
    output mvm_noc_pkg::noc_flit_t  tx_flit
);
    import mvm_noc_pkg::*;

    localparam int LANES = `MVM_LANES;
    localparam int LANEW = `MVM_LANEW;
    localparam int PRODW = 2 * LANEW;
    localparam int ACCW  = `MVM_ACCW;

    logic signed [LANEW-1:0] weight_q [LANES];
    logic signed [PRODW-1:0] prod_q   [LANES];
    logic                    prod_valid;
    logic                    prod_last;
    logic signed [ACCW-1:0]  dot_sum;
    logic signed [ACCW-1:0]  acc_q;
    logic signed [ACCW-1:0]  acc_next;
    logic [ACCW-1:0]         res_q;
    logic                    rx_fire;
    logic                    vec_fire;

    // Hold off input from a last vector beat until its result is taken
    assign rx_ready = !(tx_valid || (prod_valid && prod_last));
    assign rx_fire  = rx_valid && rx_ready;
    assign vec_fire = rx_fire && (rx_flit.op == OP_VECTOR);

    // ---------------------------------------------------------
    // Stage 1, weight load and lane products
    // ---------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rx_fire) begin
            case (rx_flit.op)
                OP_WEIGHT: begin
                    for (int k = 0; k < LANES; k++) begin
                        weight_q[k] <= rx_flit.data[k*LANEW +: LANEW];
                    end
                end
                OP_VECTOR: begin
                    for (int k = 0; k < LANES; k++) begin
                        prod_q[k] <= $signed(rx_flit.data[k*LANEW +: LANEW]) * weight_q[k];
                    end
                end
                // Results and pass-through flits are consumed
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prod_valid <= 1'b0;
            prod_last  <= 1'b0;
        end else begin
            prod_valid <= vec_fire;
            prod_last  <= vec_fire && rx_flit.last;
        end
    end

    // ---------------------------------------------------------
    // Stage 2, reduce and accumulate
    // ---------------------------------------------------------
    always_comb begin
        dot_sum = '0;
        for (int k = 0; k < LANES; k++) begin
            // Signed cast sign-extends each product
            dot_sum = dot_sum + ACCW'(prod_q[k]);
        end
        acc_next = acc_q + dot_sum;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_q    <= '0;
            tx_valid <= 1'b0;
        end else begin
            if (prod_valid) begin
                // Last beat releases and restarts from zero
                acc_q <= prod_last ? '0 : acc_next;
            end
            if (prod_valid && prod_last) begin
                tx_valid <= 1'b1;
            end else if (tx_ready) begin
                tx_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (prod_valid && prod_last) begin
            res_q <= acc_next;
        end
    end

    // Result beat always heads for the egress node
    assign tx_flit = '{
        data: res_q,
        last: 1'b1,
        op:   OP_RESULT,
        dest: `MVM_DESTW'(`MVM_OUT_NODE)
    };

endmodule

// File: noc_mesh.sv
`timescale 1ns/100ps
`include "mvm_noc_cfg.svh"

module noc_mesh (
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic                    local_in_valid  [`MVM_ROWS * `MVM_COLS],
    output logic                    local_in_ready  [`MVM_ROWS * `MVM_COLS],
    input  mvm_noc_pkg::noc_flit_t  local_in_flit   [`MVM_ROWS * `MVM_COLS],

    output logic                    local_out_valid [`MVM_ROWS * `MVM_COLS],
    input  logic                    local_out_ready [`MVM_ROWS * `MVM_COLS],
    output mvm_noc_pkg::noc_flit_t  local_out_flit  [`MVM_ROWS * `MVM_COLS]
);
    import mvm_noc_pkg::*;

    localparam int NODES = `MVM_ROWS * `MVM_COLS;

    // Router-side view of every port
    logic      r_in_valid  [NODES][NOC_PORTS];
    logic      r_in_ready  [NODES][NOC_PORTS];
    noc_flit_t r_in_flit   [NODES][NOC_PORTS];
    logic      r_out_valid [NODES][NOC_PORTS];
    logic      r_out_ready [NODES][NOC_PORTS];
    noc_flit_t r_out_flit  [NODES][NOC_PORTS];

    // Node across port p, -1 past the mesh edge
    function automatic int neighbor(input int n, input int p);
        int x;
        int y;
        x = n % `MVM_COLS;
        y = n / `MVM_COLS;
        case (p)
            PORT_EAST:  return (x < `MVM_COLS - 1) ? n + 1 : -1;
            PORT_WEST:  return (x > 0) ? n - 1 : -1;
            PORT_NORTH: return (y < `MVM_ROWS - 1) ? n + `MVM_COLS : -1;
            PORT_SOUTH: return (y > 0) ? n - `MVM_COLS : -1;
            default:    return -1;
        endcase
    endfunction

    // Port on the neighbor that faces back
    function automatic int opposite(input int p);
        case (p)
            PORT_EAST:  return PORT_WEST;
            PORT_WEST:  return PORT_EAST;
            PORT_NORTH: return PORT_SOUTH;
            default:    return PORT_NORTH;
        endcase
    endfunction

    for (genvar n = 0; n < NODES; n++) begin : g_node
        noc_router #(
            .node_x (n % `MVM_COLS),
            .node_y (n / `MVM_COLS)
        ) i_router (
            .clk       (clk),
            .arst_n    (arst_n),
            .in_valid  (r_in_valid[n]),
            .in_ready  (r_in_ready[n]),
            .in_flit   (r_in_flit[n]),
            .out_valid (r_out_valid[n]),
            .out_ready (r_out_ready[n]),
            .out_flit  (r_out_flit[n])
        );

        // Local port to the attached block
        assign r_in_valid[n][PORT_LOCAL]  = local_in_valid[n];
        assign r_in_flit[n][PORT_LOCAL]   = local_in_flit[n];
        assign local_in_ready[n]          = r_in_ready[n][PORT_LOCAL];
        assign local_out_valid[n]         = r_out_valid[n][PORT_LOCAL];
        assign local_out_flit[n]          = r_out_flit[n][PORT_LOCAL];
        assign r_out_ready[n][PORT_LOCAL] = local_out_ready[n];

        // Neighbor links, edges idle
        for (genvar p = 1; p < NOC_PORTS; p++) begin : g_link
            localparam int NB = neighbor(n, p);
            localparam int OP = opposite(p);
            if (NB >= 0) begin : g_on
                assign r_in_valid[n][p]  = r_out_valid[NB][OP];
                assign r_in_flit[n][p]   = r_out_flit[NB][OP];
                assign r_out_ready[n][p] = r_in_ready[NB][OP];
            end else begin : g_edge
                assign r_in_valid[n][p]  = 1'b0;
                assign r_in_flit[n][p]   = '0;
                assign r_out_ready[n][p] = 1'b1;
            end
        end
    end

endmodule

// File: noc_router.sv
`timescale 1ns/100ps
`include "mvm_noc_cfg.svh"

module noc_router #(
    parameter int node_x = 0,
    parameter int node_y = 0
) (
    input  logic                    clk,
    input  logic                    arst_n,

    input  logic                    in_valid  [mvm_noc_pkg::NOC_PORTS],
    output logic                    in_ready  [mvm_noc_pkg::NOC_PORTS],
    input  mvm_noc_pkg::noc_flit_t  in_flit   [mvm_noc_pkg::NOC_PORTS],

    output logic                    out_valid [mvm_noc_pkg::NOC_PORTS],
    input  logic                    out_ready [mvm_noc_pkg::NOC_PORTS],
    output mvm_noc_pkg::noc_flit_t  out_flit  [mvm_noc_pkg::NOC_PORTS]
);
    import mvm_noc_pkg::*;

    localparam int DEPTH = `MVM_FLIT_DEPTH;
    localparam int PTRW  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNTW  = $clog2(DEPTH + 1);
    localparam int SELW  = $clog2(NOC_PORTS);

    // Input FIFOs
    noc_flit_t       buf_mem    [NOC_PORTS][DEPTH];
    logic [PTRW-1:0] rd_ptr     [NOC_PORTS];
    logic [PTRW-1:0] wr_ptr     [NOC_PORTS];
    logic [CNTW-1:0] count      [NOC_PORTS];
    logic            push       [NOC_PORTS];
    logic            pop        [NOC_PORTS];
    logic            head_valid [NOC_PORTS];
    noc_flit_t       head       [NOC_PORTS];
    noc_port_e       head_dir   [NOC_PORTS];

    // Output arbitration
    logic            out_free   [NOC_PORTS];
    logic            gnt_valid  [NOC_PORTS];
    logic [SELW-1:0] gnt_idx    [NOC_PORTS];
    logic [SELW-1:0] rr_ptr     [NOC_PORTS];

    function automatic logic [PTRW-1:0] ptr_next(input logic [PTRW-1:0] ptr);
        return (int'(ptr) == DEPTH - 1) ? '0 : ptr + 1'b1;
    endfunction

    // Dimension order, X then Y
    function automatic noc_port_e route(input logic [`MVM_DESTW-1:0] dest);
        int dx;
        int dy;
        dx = int'(dest) % `MVM_COLS;
        dy = int'(dest) / `MVM_COLS;
        if (dx > node_x) begin
            return PORT_EAST;
        end else if (dx < node_x) begin
            return PORT_WEST;
        end else if (dy > node_y) begin
            return PORT_NORTH;
        end else if (dy < node_y) begin
            return PORT_SOUTH;
        end
        return PORT_LOCAL;
    endfunction

    // ---------------------------------------------------------
    // Input side
    // ---------------------------------------------------------
    always_comb begin
        for (int i = 0; i < NOC_PORTS; i++) begin
            in_ready[i]   = (count[i] != CNTW'(DEPTH));
            push[i]       = in_valid[i] && in_ready[i];
            head_valid[i] = (count[i] != '0);
            head[i]       = buf_mem[i][rd_ptr[i]];
            head_dir[i]   = route(head[i].dest);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NOC_PORTS; i++) begin
                rd_ptr[i] <= '0;
                wr_ptr[i] <= '0;
                count[i]  <= '0;
            end
        end else begin
            for (int i = 0; i < NOC_PORTS; i++) begin
                if (push[i]) begin
                    wr_ptr[i] <= ptr_next(wr_ptr[i]);
                end
                if (pop[i]) begin
                    rd_ptr[i] <= ptr_next(rd_ptr[i]);
                end
                count[i] <= count[i] + CNTW'(push[i]) - CNTW'(pop[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NOC_PORTS; i++) begin
            if (push[i]) begin
                buf_mem[i][wr_ptr[i]] <= in_flit[i];
            end
        end
    end

    // ---------------------------------------------------------
    // Round-robin arbiters and output registers
    // ---------------------------------------------------------
    always_comb begin
        for (int o = 0; o < NOC_PORTS; o++) begin
            out_free[o]  = !out_valid[o] || out_ready[o];
            gnt_valid[o] = 1'b0;
            gnt_idx[o]   = '0;
            // Scan downward so the input nearest rr_ptr wins
            for (int k = NOC_PORTS - 1; k >= 0; k--) begin
                if (head_valid[(int'(rr_ptr[o]) + k) % NOC_PORTS] &&
                    int'(head_dir[(int'(rr_ptr[o]) + k) % NOC_PORTS]) == o) begin
                    gnt_valid[o] = 1'b1;
                    gnt_idx[o]   = SELW'((int'(rr_ptr[o]) + k) % NOC_PORTS);
                end
            end
        end
        // A head targets one output, so at most one grant per input
        for (int i = 0; i < NOC_PORTS; i++) begin
            pop[i] = 1'b0;
            for (int o = 0; o < NOC_PORTS; o++) begin
                if (gnt_valid[o] && out_free[o] && int'(gnt_idx[o]) == i) begin
                    pop[i] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int o = 0; o < NOC_PORTS; o++) begin
                out_valid[o] <= 1'b0;
                rr_ptr[o]    <= '0;
            end
        end else begin
            for (int o = 0; o < NOC_PORTS; o++) begin
                if (out_free[o]) begin
                    out_valid[o] <= gnt_valid[o];
                end
                // Priority moves past the winner
                if (out_free[o] && gnt_valid[o]) begin
                    rr_ptr[o] <= (int'(gnt_idx[o]) == NOC_PORTS - 1) ? '0 : gnt_idx[o] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < NOC_PORTS; o++) begin
            if (out_free[o] && gnt_valid[o]) begin
                out_flit[o] <= head[gnt_idx[o]];
            end
        end
    end

endmodule

// File: project.f
+incdir+.
mvm_noc_pkg.sv
axis_reg_slice.sv
noc_router.sv
noc_mesh.sv
mvm_tile.sv
mvm_noc.sv
tb_mvm_noc.sv

// File: tb_mvm_noc_vectors.svh
`ifndef TB_MVM_NOC_VECTORS_SVH
`define TB_MVM_NOC_VECTORS_SVH

// ------------------------------------------------------------
// Stimulus and expected-output table
// ------------------------------------------------------------
// Columns are test number, kind, data, last, op and dest
// Kind 0 is a beat to send and kind 1 a beat expected at the output
// Data lane 0 sits in bits 7:0 and each lane is a signed byte
// Results are signed lane products summed over the vector beats
typedef struct packed {
    logic [3:0] test;
    logic       expect_out;
    noc_flit_t  flit;
} stim_row_t;

localparam int NTESTS = 7;
localparam int NROWS  = 39;

localparam logic [$bits(stim_row_t)-1:0] STIM [NROWS] = '{
    // Pass-through flits straight to the egress node
    {4'd1, 1'b0, 32'h0000_0001, 1'b0, OP_PASS,   2'd3},
    {4'd1, 1'b0, 32'hdead_beef, 1'b0, OP_PASS,   2'd3},
    {4'd1, 1'b0, 32'h1234_5678, 1'b0, OP_PASS,   2'd3},
    {4'd1, 1'b0, 32'hffff_0000, 1'b1, OP_PASS,   2'd3},
    {4'd1, 1'b1, 32'h0000_0001, 1'b0, OP_PASS,   2'd3},
    {4'd1, 1'b1, 32'hdead_beef, 1'b0, OP_PASS,   2'd3},
    {4'd1, 1'b1, 32'h1234_5678, 1'b0, OP_PASS,   2'd3},
    {4'd1, 1'b1, 32'hffff_0000, 1'b1, OP_PASS,   2'd3},
    // Single dot product on node 1
    {4'd2, 1'b0, 32'h0403_0201, 1'b0, OP_WEIGHT, 2'd1},
    {4'd2, 1'b0, 32'h0506_0708, 1'b1, OP_VECTOR, 2'd1},
    // 8 + 14 + 18 + 20 = 60
    {4'd2, 1'b1, 32'h0000_003c, 1'b1, OP_RESULT, 2'd3},
    // Two sequences back to back on node 2
    {4'd3, 1'b0, 32'hfe03_ff02, 1'b0, OP_WEIGHT, 2'd2},
    {4'd3, 1'b0, 32'h0102_0304, 1'b0, OP_VECTOR, 2'd2},
    {4'd3, 1'b0, 32'h1020_3040, 1'b0, OP_VECTOR, 2'd2},
    {4'd3, 1'b0, 32'h7f00_8105, 1'b1, OP_VECTOR, 2'd2},
    {4'd3, 1'b0, 32'h0202_0202, 1'b0, OP_VECTOR, 2'd2},
    {4'd3, 1'b0, 32'hff01_ff01, 1'b1, OP_VECTOR, 2'd2},
    // 9 + 144 - 117 = 36
    {4'd3, 1'b1, 32'h0000_0024, 1'b1, OP_RESULT, 2'd3},
    // Restarts from zero, 4 + 8 = 12
    {4'd3, 1'b1, 32'h0000_000c, 1'b1, OP_RESULT, 2'd3},
    // Signed corners with -128 by -128 in lanes 0 and 3
    {4'd4, 1'b0, 32'h80ff_7f80, 1'b0, OP_WEIGHT, 2'd1},
    {4'd4, 1'b0, 32'h8080_0180, 1'b1, OP_VECTOR, 2'd1},
    // 16384 + 127 + 128 + 16384 = 33023
    {4'd4, 1'b1, 32'h0000_80ff, 1'b1, OP_RESULT, 2'd3},
    // Same paths again under output stalls
    {4'd5, 1'b0, 32'hcafe_f00d, 1'b0, OP_PASS,   2'd3},
    {4'd5, 1'b0, 32'h0bad_c0de, 1'b0, OP_PASS,   2'd3},
    {4'd5, 1'b0, 32'h8000_0000, 1'b0, OP_PASS,   2'd3},
    {4'd5, 1'b0, 32'h7fff_ffff, 1'b0, OP_PASS,   2'd3},
    {4'd5, 1'b0, 32'h5a5a_a5a5, 1'b1, OP_PASS,   2'd3},
    {4'd5, 1'b1, 32'hcafe_f00d, 1'b0, OP_PASS,   2'd3},
    {4'd5, 1'b1, 32'h0bad_c0de, 1'b0, OP_PASS,   2'd3},
    {4'd5, 1'b1, 32'h8000_0000, 1'b0, OP_PASS,   2'd3},
    {4'd5, 1'b1, 32'h7fff_ffff, 1'b0, OP_PASS,   2'd3},
    {4'd5, 1'b1, 32'h5a5a_a5a5, 1'b1, OP_PASS,   2'd3},
    // Keeps the weights from test 4
    {4'd6, 1'b0, 32'h1122_3344, 1'b0, OP_VECTOR, 2'd1},
    {4'd6, 1'b0, 32'h807f_807f, 1'b1, OP_VECTOR, 2'd1},
    // -4437 - 16255 = -20692
    {4'd6, 1'b1, 32'hffff_af2c, 1'b1, OP_RESULT, 2'd3},
    {4'd7, 1'b0, 32'h8080_8080, 1'b0, OP_WEIGHT, 2'd2},
    {4'd7, 1'b0, 32'h8080_8080, 1'b0, OP_VECTOR, 2'd2},
    {4'd7, 1'b0, 32'h7f01_ff80, 1'b1, OP_VECTOR, 2'd2},
    // 65536 + 128 = 65664
    {4'd7, 1'b1, 32'h0001_0080, 1'b1, OP_RESULT, 2'd3}
};

// Tests run with random m_ready
localparam logic TEST_STALL [NTESTS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};

// Fibonacci LFSR with taps 32 22 2 1
// New bit enters at bit 0
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

`endif

// File: tb_mvm_noc.sv
`timescale 1ns/100ps

module tb_mvm_noc;
    import mvm_noc_pkg::*;

    `include "tb_mvm_noc_vectors.svh"

    localparam logic [31:0] LFSR_SEED      = 32'he9d1_6390;
    localparam int          TIMEOUT_CYCLES = 8 * NROWS + 200;

    logic      clk;
    logic      arst_n;
    logic      s_valid;
    logic      s_ready;
    noc_flit_t s_flit;
    logic      m_valid;
    logic      m_ready;
    noc_flit_t m_flit;

    // Output beats still to come, in order
    noc_flit_t exp_q [$];

    logic        stall_en;
    logic [31:0] lfsr;
    int          errors;
    int          tests_pass;
    int          tests_fail;
    int          cycles;

    mvm_noc i_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .s_flit  (s_flit),
        .m_valid (m_valid),
        .m_ready (m_ready),
        .m_flit  (m_flit)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic check_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
            errors++;
        end
    endtask

    // Starts and ends 1 ns after a rising edge
    task automatic send_beat(input noc_flit_t f);
        logic taken;
        s_valid = 1'b1;
        s_flit  = f;
        taken   = 1'b0;
        while (!taken) begin
            // s_ready only moves on the rising edge
            @(negedge clk);
            taken = s_ready;
            @(posedge clk);
            #1;
        end
        s_valid = 1'b0;
    endtask

    // ------------------------------------------------------------
    // Output side
    // ------------------------------------------------------------
    always @(posedge clk) begin : ready_drive
        logic use_stall;
        use_stall = stall_en;
        #1;
        if (use_stall) begin
            lfsr    = lfsr_next(lfsr);
            m_ready = lfsr[0];
        end else begin
            m_ready = 1'b1;
        end
    end

    // Mid-cycle sample sees the values of the coming edge
    always @(negedge clk) begin : monitor
        noc_flit_t e;
        if (arst_n && m_valid && m_ready) begin
            assert (exp_q.size() != 0) else begin
                $display("Unexpected output beat at %0t ns with data %h", $time, m_flit.data);
                errors++;
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                check_field("m_flit.data", e.data, m_flit.data);
                check_field("m_flit.last", 32'(e.last), 32'(m_flit.last));
                check_field("m_flit.op", 32'(e.op), 32'(m_flit.op));
                check_field("m_flit.dest", 32'(e.dest), 32'(m_flit.dest));
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d output beats still missing",
                 cycles, exp_q.size());
        $display("** FAIL **");
        $finish;
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin : stimulus
        stim_row_t row;
        int        n_in;
        int        n_out;
        int        errs_before;
        arst_n     = 1'b0;
        s_valid    = 1'b0;
        s_flit     = '0;
        m_ready    = 1'b1;
        stall_en   = 1'b0;
        lfsr       = LFSR_SEED;
        errors     = 0;
        tests_pass = 0;
        tests_fail = 0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Output must stay idle with nothing sent
        repeat (5) begin
            @(negedge clk);
            assert (m_valid === 1'b0) else begin
                $display("m_valid went high at %0t ns before any input", $time);
                errors++;
            end
        end
        @(posedge clk);
        #1;

        for (int t = 1; t <= NTESTS; t++) begin
            errs_before = errors;
            n_in        = 0;
            n_out       = 0;
            // Whole expected sequence is known before the first beat goes in
            for (int r = 0; r < NROWS; r++) begin
                row = STIM[r];
                if (int'(row.test) == t && row.expect_out) begin
                    exp_q.push_back(row.flit);
                    n_out++;
                end
            end
            stall_en = TEST_STALL[t-1];
            for (int r = 0; r < NROWS; r++) begin
                row = STIM[r];
                if (int'(row.test) == t && !row.expect_out) begin
                    send_beat(row.flit);
                    n_in++;
                end
            end
            // Drain so paths of later tests cannot overtake
            while (exp_q.size() != 0) begin
                @(posedge clk);
                #1;
            end
            stall_en = 1'b0;
            // Quiet gap catches extra beats
            repeat (4) begin
                @(posedge clk);
                #1;
            end
            if (errors == errs_before) begin
                tests_pass++;
            end else begin
                tests_fail++;
            end
            $display("Test %0d: %0d beats in, %0d beats out, %s", t, n_in, n_out,
                     (errors == errs_before) ? "ok" : "mismatch");
        end

        $display("Tests ok %0d, tests with errors %0d, error count %0d",
                 tests_pass, tests_fail, errors);
        if (tests_fail == 0 && errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
